//--- Bender.yml
package:
  name: soc_bus

sources:
  - logic/bus_pkg.sv
  - logic/bus_arbiter.sv
  - logic/scratch_sram.sv
  - logic/serial_port.sv
  - logic/core_timer.sv
  - logic/soc_bus_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_soc_bus.sv

vendor_package: []

//--- logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic             clk,
  input  logic             rst_i,
  // requesters
  input  logic             ifu_arvalid_i,
  input  bus_pkg::rd_req_t ifu_rd_req_i,
  input  logic             lsu_arvalid_i,
  input  bus_pkg::rd_req_t lsu_rd_req_i,
  input  logic             lsu_awvalid_i,
  input  bus_pkg::wr_req_t lsu_wr_req_i,
  output logic             ifu_rvalid_o,
  output bus_pkg::rd_rsp_t ifu_rd_rsp_o,
  output logic             lsu_rvalid_o,
  output bus_pkg::rd_rsp_t lsu_rd_rsp_o,
  output logic             lsu_wready_o,
  // device side
  output bus_pkg::rd_req_t dev_rd_req_o,
  output bus_pkg::wr_req_t dev_wr_req_o,
  output logic             sram_rd_o,
  output logic             sram_wr_o,
  output logic             serial_wr_o,
  output logic             timer_rd_o,
  input  logic             sram_rvalid_i,
  input  bus_pkg::rd_rsp_t sram_rd_rsp_i,
  input  logic             sram_wdone_i,
  input  logic             serial_wdone_i,
  input  logic             timer_rvalid_i,
  input  bus_pkg::rd_rsp_t timer_rd_rsp_i
);
  import bus_pkg::*;

  arb_state_e state_q, state_d;
  dev_sel_e   sel_q, sel_d;
  rd_req_t    rd_req_q;
  wr_req_t    wr_req_q;
  logic       issued_q;
  logic       issue;
  logic       is_rd;
  logic       is_wr;
  logic       rd_done;
  logic       wr_done;
  rd_rsp_t    rd_rsp;

  assign is_rd = (state_q == IFU_RD) || (state_q == LSU_RD);
  assign is_wr = (state_q == LSU_WR);
  // first cycle after the latch
  assign issue = (state_q != IDLE) && !issued_q;

  // lsu store wins, then lsu load, then fetch
  always_comb begin
    state_d = state_q;
    sel_d   = sel_q;
    case (state_q)
      IDLE: begin
        if (lsu_awvalid_i) begin
          state_d = LSU_WR;
          sel_d   = addr_decode(lsu_wr_req_i.addr);
        end else if (lsu_arvalid_i) begin
          state_d = LSU_RD;
          sel_d   = addr_decode(lsu_rd_req_i.addr);
        end else if (ifu_arvalid_i) begin
          state_d = IFU_RD;
          sel_d   = addr_decode(ifu_rd_req_i.addr);
        end
      end
      IFU_RD, LSU_RD: begin
        if (rd_done) state_d = IDLE;
      end
      LSU_WR: begin
        if (wr_done) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= IDLE;
      sel_q   <= SRAM;
    end else begin
      state_q <= state_d;
      sel_q   <= sel_d;
    end
  end

  // request fields held for the whole transaction
  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      if (lsu_awvalid_i) begin
        wr_req_q <= lsu_wr_req_i;
      end else if (lsu_arvalid_i) begin
        rd_req_q <= lsu_rd_req_i;
      end else if (ifu_arvalid_i) begin
        rd_req_q <= ifu_rd_req_i;
      end
    end
  end

  // one strobe per transaction, a cycle after the latch
  always_ff @(posedge clk) begin
    if (rst_i) begin
      issued_q    <= 1'b0;
      sram_rd_o   <= 1'b0;
      sram_wr_o   <= 1'b0;
      serial_wr_o <= 1'b0;
      timer_rd_o  <= 1'b0;
    end else begin
      issued_q    <= (state_q != IDLE);
      sram_rd_o   <= issue && is_rd && (sel_q == SRAM);
      sram_wr_o   <= issue && is_wr && (sel_q == SRAM);
      serial_wr_o <= issue && is_wr && (sel_q == SERIAL);
      timer_rd_o  <= issue && is_rd && (sel_q == TIMER);
    end
  end

  assign dev_rd_req_o = rd_req_q;
  assign dev_wr_req_o = wr_req_q;

  // response routing from the selected device
  always_comb begin
    rd_done = 1'b0;
    wr_done = 1'b0;
    rd_rsp  = '{data: '0, resp: RESP_DECERR};
    case (sel_q)
      SRAM: begin
        rd_done = sram_rvalid_i;
        rd_rsp  = sram_rd_rsp_i;
        wr_done = sram_wdone_i;
      end
      SERIAL: begin
        // no read side on the serial port, answered here
        rd_done = 1'b1;
        wr_done = serial_wdone_i;
      end
      TIMER: begin
        rd_done = timer_rvalid_i;
        rd_rsp  = timer_rd_rsp_i;
        // timer is read-only, stores are dropped
        wr_done = 1'b1;
      end
      default: ;
    endcase
  end

  assign ifu_rvalid_o = (state_q == IFU_RD) && rd_done;
  assign lsu_rvalid_o = (state_q == LSU_RD) && rd_done;
  assign lsu_wready_o = is_wr && wr_done;
  assign ifu_rd_rsp_o = rd_rsp;
  assign lsu_rd_rsp_o = rd_rsp;

endmodule

//--- logic/bus_pkg.sv
package bus_pkg;

  // bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;
  typedef logic [7:0]  uart_byte_t;
  typedef logic [63:0] cycle_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_DECERR = 2'd2;

  // device address map, everything else lands in the SRAM
  localparam addr_t SERIAL_ADDR   = 32'ha000_03f8;
  localparam addr_t TIMER_ADDR_LO = 32'ha000_0048;
  localparam addr_t TIMER_ADDR_HI = 32'ha000_004c;

  typedef struct packed {
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } wr_req_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } rd_rsp_t;

  typedef enum logic [1:0] {SRAM, SERIAL, TIMER} dev_sel_e;

  typedef enum logic [1:0] {IDLE, IFU_RD, LSU_RD, LSU_WR} arb_state_e;

  function automatic dev_sel_e addr_decode(input addr_t addr);
    dev_sel_e sel;
    case (addr)
      SERIAL_ADDR:                  sel = SERIAL;
      TIMER_ADDR_LO, TIMER_ADDR_HI: sel = TIMER;
      default:                      sel = SRAM;
    endcase
    return sel;
  endfunction

endpackage

//--- logic/core_timer.sv
`timescale 1ns/1ps

module core_timer (
  input  logic             clk,
  input  logic             rst_i,
  input  logic             rd_i,
  input  bus_pkg::rd_req_t rd_req_i,
  output logic             rvalid_o,
  output bus_pkg::rd_rsp_t rd_rsp_o
);
  import bus_pkg::*;

  cycle_t count_q;
  data_t  rdata_q;
  logic   hi_sel;

  assign hi_sel = (rd_req_i.addr == TIMER_ADDR_HI);

  // free-running cycle count
  always_ff @(posedge clk) begin
    if (rst_i) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= rd_i;
    end
  end

  // halves are sampled separately
  always_ff @(posedge clk) begin
    if (rd_i) begin
      rdata_q <= hi_sel ? count_q[63:32] : count_q[31:0];
    end
  end

  assign rd_rsp_o = '{data: rdata_q, resp: RESP_OKAY};

endmodule

//--- logic/scratch_sram.sv
`timescale 1ns/1ps

module scratch_sram #(
  parameter int SRAM_ADDR_W  = 8,
  parameter int SRAM_LATENCY = 2
) (
  input  logic             clk,
  input  logic             rst_i,
  input  logic             rd_i,
  input  bus_pkg::rd_req_t rd_req_i,
  input  logic             wr_i,
  input  bus_pkg::wr_req_t wr_req_i,
  output logic             rvalid_o,
  output bus_pkg::rd_rsp_t rd_rsp_o,
  output logic             wdone_o
);
  import bus_pkg::*;

  localparam int DEPTH = 1 << SRAM_ADDR_W;

  typedef logic [SRAM_ADDR_W-1:0] idx_t;

  data_t                   mem [DEPTH];
  data_t                   data_pipe [SRAM_LATENCY];
  logic [SRAM_LATENCY-1:0] vld_pipe;
  idx_t                    rd_idx;
  idx_t                    wr_idx;

  // word index, upper address bits wrap
  assign rd_idx = rd_req_i.addr[SRAM_ADDR_W+1:2];
  assign wr_idx = wr_req_i.addr[SRAM_ADDR_W+1:2];

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // byte-masked store
  always_ff @(posedge clk) begin
    if (wr_i) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_req_i.strb[b]) begin
          mem[wr_idx][8*b +: 8] <= wr_req_i.data[8*b +: 8];
        end
      end
    end
  end

  // read delay line
  always_ff @(posedge clk) begin
    if (rd_i) begin
      data_pipe[0] <= mem[rd_idx];
    end
    for (int s = 1; s < SRAM_LATENCY; s++) begin
      data_pipe[s] <= data_pipe[s-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      vld_pipe <= '0;
      wdone_o  <= 1'b0;
    end else begin
      vld_pipe[0] <= rd_i;
      for (int s = 1; s < SRAM_LATENCY; s++) begin
        vld_pipe[s] <= vld_pipe[s-1];
      end
      wdone_o <= wr_i;
    end
  end

  assign rvalid_o = vld_pipe[SRAM_LATENCY-1];
  assign rd_rsp_o = '{data: data_pipe[SRAM_LATENCY-1], resp: RESP_OKAY};

endmodule

//--- logic/serial_port.sv
`timescale 1ns/1ps

module serial_port (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                wr_i,
  input  bus_pkg::wr_req_t    wr_req_i,
  output logic                uart_tx_valid_o,
  output bus_pkg::uart_byte_t uart_tx_data_o,
  output logic                wdone_o
);
  import bus_pkg::*;

  logic    byte_en;
  uart_byte_t tx_byte;

  // only the low byte lane carries a character
  assign byte_en = wr_i && wr_req_i.strb[0];
  assign tx_byte = wr_req_i.data[7:0];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      uart_tx_valid_o <= 1'b0;
      wdone_o         <= 1'b0;
    end else begin
      uart_tx_valid_o <= byte_en;
      // store completes even without a byte
      wdone_o         <= wr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (byte_en) begin
      uart_tx_data_o <= tx_byte;
    end
  end

endmodule

//--- logic/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top #(
  parameter int SRAM_ADDR_W  = 8,
  parameter int SRAM_LATENCY = 2
) (
  input  logic                clk,
  input  logic                rst_i,
  input  bus_pkg::rd_req_t    ifu_rd_req_i,
  input  logic                ifu_arvalid_i,
  output bus_pkg::rd_rsp_t    ifu_rd_rsp_o,
  output logic                ifu_rvalid_o,
  input  bus_pkg::rd_req_t    lsu_rd_req_i,
  input  logic                lsu_arvalid_i,
  output bus_pkg::rd_rsp_t    lsu_rd_rsp_o,
  output logic                lsu_rvalid_o,
  input  bus_pkg::wr_req_t    lsu_wr_req_i,
  input  logic                lsu_awvalid_i,
  output logic                lsu_wready_o,
  output logic                uart_tx_valid_o,
  output bus_pkg::uart_byte_t uart_tx_data_o
);
  import bus_pkg::*;

  rd_req_t dev_rd_req;
  wr_req_t dev_wr_req;
  logic    sram_rd;
  logic    sram_wr;
  logic    serial_wr;
  logic    timer_rd;
  logic    sram_rvalid;
  rd_rsp_t sram_rd_rsp;
  logic    sram_wdone;
  logic    serial_wdone;
  logic    timer_rvalid;
  rd_rsp_t timer_rd_rsp;

  bus_arbiter i_bus_arbiter (
    .clk            (clk),
    .rst_i          (rst_i),
    .ifu_arvalid_i  (ifu_arvalid_i),
    .ifu_rd_req_i   (ifu_rd_req_i),
    .lsu_arvalid_i  (lsu_arvalid_i),
    .lsu_rd_req_i   (lsu_rd_req_i),
    .lsu_awvalid_i  (lsu_awvalid_i),
    .lsu_wr_req_i   (lsu_wr_req_i),
    .ifu_rvalid_o   (ifu_rvalid_o),
    .ifu_rd_rsp_o   (ifu_rd_rsp_o),
    .lsu_rvalid_o   (lsu_rvalid_o),
    .lsu_rd_rsp_o   (lsu_rd_rsp_o),
    .lsu_wready_o   (lsu_wready_o),
    .dev_rd_req_o   (dev_rd_req),
    .dev_wr_req_o   (dev_wr_req),
    .sram_rd_o      (sram_rd),
    .sram_wr_o      (sram_wr),
    .serial_wr_o    (serial_wr),
    .timer_rd_o     (timer_rd),
    .sram_rvalid_i  (sram_rvalid),
    .sram_rd_rsp_i  (sram_rd_rsp),
    .sram_wdone_i   (sram_wdone),
    .serial_wdone_i (serial_wdone),
    .timer_rvalid_i (timer_rvalid),
    .timer_rd_rsp_i (timer_rd_rsp)
  );

  scratch_sram #(
    .SRAM_ADDR_W  (SRAM_ADDR_W),
    .SRAM_LATENCY (SRAM_LATENCY)
  ) i_scratch_sram (
    .clk      (clk),
    .rst_i    (rst_i),
    .rd_i     (sram_rd),
    .rd_req_i (dev_rd_req),
    .wr_i     (sram_wr),
    .wr_req_i (dev_wr_req),
    .rvalid_o (sram_rvalid),
    .rd_rsp_o (sram_rd_rsp),
    .wdone_o  (sram_wdone)
  );

  serial_port i_serial_port (
    .clk             (clk),
    .rst_i           (rst_i),
    .wr_i            (serial_wr),
    .wr_req_i        (dev_wr_req),
    .uart_tx_valid_o (uart_tx_valid_o),
    .uart_tx_data_o  (uart_tx_data_o),
    .wdone_o         (serial_wdone)
  );

  core_timer i_core_timer (
    .clk      (clk),
    .rst_i    (rst_i),
    .rd_i     (timer_rd),
    .rd_req_i (dev_rd_req),
    .rvalid_o (timer_rvalid),
    .rd_rsp_o (timer_rd_rsp)
  );

endmodule

//--- project.f
+incdir+testbench
logic/bus_pkg.sv
logic/bus_arbiter.sv
logic/scratch_sram.sv
logic/serial_port.sv
logic/core_timer.sv
logic/soc_bus_top.sv
testbench/tb_soc_bus.sv

//--- testbench/tb_bus_model.svh
`ifndef TB_BUS_MODEL_SVH
`define TB_BUS_MODEL_SVH

// shadow of the scratch SRAM, cleared like the memory at start
data_t      shadow_mem [SRAM_DEPTH];
uart_byte_t uart_q [$];
addr_t      written_q [$];
data_t      last_timer_lo;

function automatic void clear_model();
  foreach (shadow_mem[i]) begin
    shadow_mem[i] = '0;
  end
  last_timer_lo = '0;
endfunction

function automatic dev_sel_e classify_addr(input addr_t addr);
  if (addr == SERIAL_ADDR) return SERIAL;
  if (addr == TIMER_ADDR_LO || addr == TIMER_ADDR_HI) return TIMER;
  return SRAM;
endfunction

// only the word index modulo the depth selects a word
function automatic int word_index(input addr_t addr);
  return int'((addr >> 2) % SRAM_DEPTH);
endfunction

function automatic void model_store(input addr_t addr, input data_t data, input strb_t strb);
  case (classify_addr(addr))
    SERIAL: begin
      if (strb[0]) uart_q.push_back(data[7:0]);
    end
    TIMER: ;
    default: begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) shadow_mem[word_index(addr)][8*b +: 8] = data[8*b +: 8];
      end
      written_q.push_back(addr);
    end
  endcase
endfunction

function automatic rd_rsp_t expected_read(input addr_t addr);
  rd_rsp_t rsp;
  rsp.resp = RESP_OKAY;
  rsp.data = '0;
  if (classify_addr(addr) == SERIAL) begin
    rsp.resp = RESP_DECERR;
  end else if (classify_addr(addr) == SRAM) begin
    rsp.data = shadow_mem[word_index(addr)];
  end
  return rsp;
endfunction

`endif

//--- testbench/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;
  import bus_pkg::*;

  localparam int SRAM_ADDR_W  = 8;
  localparam int SRAM_LATENCY = 2;
  localparam int SRAM_DEPTH   = 1 << SRAM_ADDR_W;
  localparam int N_RANDOM     = 200;
  localparam int N_FETCH      = 100;
  localparam int N_SERIAL     = 8;
  localparam int N_TIMER      = 5;
  // every transaction of the run, the full SRAM sweep included
  localparam int N_TRANS = 1 + N_RANDOM + N_FETCH + 2 + N_SERIAL + 2 + SRAM_DEPTH + N_TIMER + 1;
  localparam int WATCHDOG_CYCLES = N_TRANS * (SRAM_LATENCY + 8) + 200;

  logic       clk;
  logic       rst_i;
  rd_req_t    ifu_rd_req_i;
  logic       ifu_arvalid_i;
  rd_rsp_t    ifu_rd_rsp_o;
  logic       ifu_rvalid_o;
  rd_req_t    lsu_rd_req_i;
  logic       lsu_arvalid_i;
  rd_rsp_t    lsu_rd_rsp_o;
  logic       lsu_rvalid_o;
  wr_req_t    lsu_wr_req_i;
  logic       lsu_awvalid_i;
  logic       lsu_wready_o;
  logic       uart_tx_valid_o;
  uart_byte_t uart_tx_data_o;

  integer      seed = 86;
  int          errors = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  int          uart_seen = 0;
  logic [63:0] cycle_cnt;

  `include "tb_bus_model.svh"

  soc_bus_top #(
    .SRAM_ADDR_W  (SRAM_ADDR_W),
    .SRAM_LATENCY (SRAM_LATENCY)
  ) i_soc_bus_top (
    .clk             (clk),
    .rst_i           (rst_i),
    .ifu_rd_req_i    (ifu_rd_req_i),
    .ifu_arvalid_i   (ifu_arvalid_i),
    .ifu_rd_rsp_o    (ifu_rd_rsp_o),
    .ifu_rvalid_o    (ifu_rvalid_o),
    .lsu_rd_req_i    (lsu_rd_req_i),
    .lsu_arvalid_i   (lsu_arvalid_i),
    .lsu_rd_rsp_o    (lsu_rd_rsp_o),
    .lsu_rvalid_o    (lsu_rvalid_o),
    .lsu_wr_req_i    (lsu_wr_req_i),
    .lsu_awvalid_i   (lsu_awvalid_i),
    .lsu_wready_o    (lsu_wready_o),
    .uart_tx_valid_o (uart_tx_valid_o),
    .uart_tx_data_o  (uart_tx_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the bus gave no done pulse within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // upper bound for timer reads
  always @(posedge clk) begin
    if (rst_i) cycle_cnt <= '0;
    else cycle_cnt <= cycle_cnt + 64'd1;
  end

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // every transmitted byte must be the oldest one expected
  always @(negedge clk) begin
    if (!rst_i && uart_tx_valid_o) begin
      uart_seen++;
      if (uart_q.size() == 0) begin
        errors++;
        $display("[FAIL] %0t: serial byte 0x%02h sent with none expected", $time, uart_tx_data_o);
      end else begin
        check_value("serial byte", uart_tx_data_o, uart_q.pop_front());
      end
    end
  end

  function automatic data_t rand_word();
    return $random(seed);
  endfunction

  // bit 31 clear keeps clear of the device addresses
  function automatic addr_t sram_addr();
    return rand_word() & 32'h7fff_ffff;
  endfunction

  function automatic addr_t mixed_addr();
    data_t r;
    r = rand_word();
    if (written_q.size() > 0 && r[0]) return written_q[r[31:1] % written_q.size()];
    return sram_addr();
  endfunction

  task automatic finish_test(input string name, input int mark);
    if (errors == mark) begin
      tests_ok++;
      $display("test %s: passed", name);
    end else begin
      tests_bad++;
      $display("test %s: failed with %0d mismatches", name, errors - mark);
    end
  endtask

  // cycles counts negedges, the first one falls before valid is sampled
  task automatic load_word(input addr_t addr, output rd_rsp_t rsp, output int cycles);
    @(posedge clk);
    lsu_rd_req_i.addr <= addr;
    lsu_arvalid_i     <= 1'b1;
    @(negedge clk);
    cycles = 1;
    while (!lsu_rvalid_o) begin
      @(negedge clk);
      cycles++;
    end
    rsp = lsu_rd_rsp_o;
    @(posedge clk);
    lsu_arvalid_i <= 1'b0;
  endtask

  task automatic fetch_word(input addr_t addr, output rd_rsp_t rsp);
    @(posedge clk);
    ifu_rd_req_i.addr <= addr;
    ifu_arvalid_i     <= 1'b1;
    @(negedge clk);
    while (!ifu_rvalid_o) @(negedge clk);
    rsp = ifu_rd_rsp_o;
    @(posedge clk);
    ifu_arvalid_i <= 1'b0;
  endtask

  task automatic store_word(input addr_t addr, input data_t data, input strb_t strb);
    @(posedge clk);
    lsu_wr_req_i.addr <= addr;
    lsu_wr_req_i.data <= data;
    lsu_wr_req_i.strb <= strb;
    lsu_awvalid_i     <= 1'b1;
    @(negedge clk);
    while (!lsu_wready_o) @(negedge clk);
    @(posedge clk);
    lsu_awvalid_i <= 1'b0;
  endtask

  task automatic contend_reads(input addr_t ifu_addr, input addr_t lsu_addr);
    rd_rsp_t ifu_rsp;
    rd_rsp_t lsu_rsp;
    rd_rsp_t exp_rsp;
    int      n = 0;
    int      tail = 0;
    int      ifu_cnt = 0;
    int      lsu_cnt = 0;
    int      ifu_at = 0;
    int      lsu_at = 0;
    logic    ifu_hit;
    logic    lsu_hit;
    @(posedge clk);
    ifu_rd_req_i.addr <= ifu_addr;
    ifu_arvalid_i     <= 1'b1;
    lsu_rd_req_i.addr <= lsu_addr;
    lsu_arvalid_i     <= 1'b1;
    // quiet cycles after both are served catch a second pulse
    while (ifu_cnt == 0 || lsu_cnt == 0 || tail < 4) begin
      @(negedge clk);
      n++;
      ifu_hit = ifu_rvalid_o;
      lsu_hit = lsu_rvalid_o;
      if (ifu_hit) begin
        ifu_cnt++;
        ifu_at  = n;
        ifu_rsp = ifu_rd_rsp_o;
      end
      if (lsu_hit) begin
        lsu_cnt++;
        lsu_at  = n;
        lsu_rsp = lsu_rd_rsp_o;
      end
      if (ifu_cnt > 0 && lsu_cnt > 0) tail++;
      @(posedge clk);
      if (ifu_hit) ifu_arvalid_i <= 1'b0;
      if (lsu_hit) lsu_arvalid_i <= 1'b0;
    end
    check_value("lsu done before ifu done", lsu_at < ifu_at, 1);
    check_value("lsu done pulses", lsu_cnt, 1);
    check_value("ifu done pulses", ifu_cnt, 1);
    exp_rsp = expected_read(lsu_addr);
    check_value("contended lsu data", lsu_rsp.data, exp_rsp.data);
    exp_rsp = expected_read(ifu_addr);
    check_value("contended ifu data", ifu_rsp.data, exp_rsp.data);
  endtask

  initial begin
    rd_rsp_t rsp;
    rd_rsp_t exp_rsp;
    int      cycles;
    int      mark;
    addr_t   addr;
    data_t   data;
    strb_t   strb;
    rst_i         = 1'b1;
    ifu_rd_req_i  = '0;
    ifu_arvalid_i = 1'b0;
    lsu_rd_req_i  = '0;
    lsu_arvalid_i = 1'b0;
    lsu_wr_req_i  = '0;
    lsu_awvalid_i = 1'b0;
    clear_model();
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;

    mark = errors;
    repeat (4) begin
      @(negedge clk);
      check_value("bus quiet after reset",
                  {ifu_rvalid_o, lsu_rvalid_o, lsu_wready_o, uart_tx_valid_o}, 0);
    end
    load_word(sram_addr(), rsp, cycles);
    check_value("idle load latency", cycles - 1, 2 + SRAM_LATENCY);
    check_value("load after reset", rsp.data, 0);
    finish_test("reset and latency", mark);

    mark = errors;
    for (int i = 0; i < N_RANDOM; i++) begin
      data = rand_word();
      if (data[4]) begin
        addr = sram_addr();
        strb = rand_word();
        data = rand_word();
        model_store(addr, data, strb);
        store_word(addr, data, strb);
      end else begin
        addr = mixed_addr();
        load_word(addr, rsp, cycles);
        exp_rsp = expected_read(addr);
        check_value("sram load data", rsp.data, exp_rsp.data);
        check_value("sram load resp", rsp.resp, RESP_OKAY);
      end
    end
    finish_test("random sram traffic", mark);

    mark = errors;
    for (int i = 0; i < N_FETCH; i++) begin
      addr = mixed_addr();
      fetch_word(addr, rsp);
      exp_rsp = expected_read(addr);
      check_value("fetch data", rsp.data, exp_rsp.data);
      check_value("fetch resp", rsp.resp, RESP_OKAY);
    end
    finish_test("instruction fetch", mark);

    mark = errors;
    contend_reads(mixed_addr(), mixed_addr());
    finish_test("contention", mark);

    mark = errors;
    for (int i = 0; i < N_SERIAL; i++) begin
      data    = rand_word();
      strb    = rand_word();
      strb[0] = 1'b1;
      model_store(SERIAL_ADDR, data, strb);
      store_word(SERIAL_ADDR, data, strb);
    end
    // no byte lane 0, completes silently
    strb    = rand_word();
    strb[0] = 1'b0;
    model_store(SERIAL_ADDR, data, strb);
    store_word(SERIAL_ADDR, data, strb);
    load_word(SERIAL_ADDR, rsp, cycles);
    exp_rsp = expected_read(SERIAL_ADDR);
    check_value("serial load data", rsp.data, exp_rsp.data);
    check_value("serial load resp", rsp.resp, exp_rsp.resp);
    check_value("serial bytes sent", uart_seen, N_SERIAL);
    check_value("serial bytes pending", uart_q.size(), 0);
    for (int i = 0; i < SRAM_DEPTH; i++) begin
      addr = addr_t'(i) << 2;
      load_word(addr, rsp, cycles);
      exp_rsp = expected_read(addr);
      check_value($sformatf("sram word %0d after serial", i), rsp.data, exp_rsp.data);
    end
    finish_test("serial port", mark);

    mark = errors;
    for (int i = 0; i < N_TIMER; i++) begin
      load_word(TIMER_ADDR_LO, rsp, cycles);
      check_value($sformatf("timer low 0x%0h above 0x%0h", rsp.data, last_timer_lo),
                  rsp.data > last_timer_lo, 1);
      check_value($sformatf("timer low 0x%0h below cycle count", rsp.data),
                  rsp.data < cycle_cnt, 1);
      check_value("timer resp", rsp.resp, RESP_OKAY);
      last_timer_lo = rsp.data;
    end
    load_word(TIMER_ADDR_HI, rsp, cycles);
    check_value("timer high word", rsp.data, 0);
    finish_test("timer", mark);

    $display("tests passed: %0d, tests failed: %0d, mismatches: %0d",
             tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
